//--- Bender.yml
package:
  name: packet_buffer

sources:
  - hw/pkt_pkg.sv
  - hw/key_debounce.sv
  - hw/packet_entry.sv
  - hw/class_buffer.sv
  - hw/read_scheduler.sv
  - hw/packet_buffer_top.sv
  - target: test
    files:
      - sim/packet_buffer_properties.sv
      - sim/tb_packet_buffer.sv

//--- hw/class_buffer.sv
module class_buffer #(
	parameter int unsigned CLASS_ID = 0
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         push,
	input  logic [pkt_pkg::DATA_W-1:0]   push_data,
	input  logic                         pop,
	output logic [pkt_pkg::FILL_W-1:0]   fill,
	output logic [pkt_pkg::DATA_W-1:0]   head,
	output logic [pkt_pkg::WEIGHT_W-1:0] weight
);
	import pkt_pkg::*;

	logic [DATA_W-1:0] mem [BUF_DEPTH]; // entry 0 is the oldest
	logic              full;
	logic              pop_ok;
	logic              shift;
	logic [FILL_W-1:0] wr_idx;
	logic [FILL_W-1:0] fill_next;

	assign full   = (fill == FILL_W'(BUF_DEPTH));
	assign pop_ok = pop && (fill != '0);
	assign shift  = pop_ok || (push && full); // full push drops the head
	assign wr_idx = shift ? fill - 1'b1 : fill;
	assign head   = mem[0];

	always_comb begin
		fill_next = fill;
		if (push && !pop_ok && !full) begin
			fill_next = fill + 1'b1;
		end else if (pop_ok && !push) begin
			fill_next = fill - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (shift) begin
			for (int i = 0; i < BUF_DEPTH - 1; i++) begin
				mem[i] <= mem[i + 1];
			end
		end
		if (push) begin
			mem[wr_idx] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			fill   <= '0;
			weight <= '0;
		end else begin
			fill   <= fill_next;
			weight <= WEIGHT_TABLE[CLASS_ID][fill_next]; // follows the new fill level
		end
	end

endmodule

//--- hw/key_debounce.sv
module key_debounce (
	input  logic clk,
	input  logic reset,
	input  logic key,
	output logic pressed
);
	import pkt_pkg::*;

	logic                  key_sync;   // registered copy of the raw key
	logic                  level;      // debounced level, high when released
	logic [DEBOUNCE_W-1:0] stable_cnt; // cycles the new level has held
	logic                  settle;

	// new level has held long enough to be accepted
	assign settle = (key_sync != level) && (stable_cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (!reset) begin
			key_sync   <= 1'b1;
			level      <= 1'b1;
			stable_cnt <= '0;
			pressed    <= 1'b0;
		end else begin
			key_sync <= key;
			pressed  <= settle && !key_sync; // one cycle, on the falling debounced level
			if (key_sync == level) begin
				stable_cnt <= '0; // glitch ended, start over
			end else if (settle) begin
				level      <= key_sync;
				stable_cnt <= '0;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

//--- hw/packet_buffer_top.sv
module packet_buffer_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               start_key,
	input  logic               key0,
	input  logic               key1,
	output logic               out_valid,
	output pkt_pkg::packet_t   out_pkt,
	input  logic               out_ready,
	output pkt_pkg::fill_vec_t fills
);
	import pkt_pkg::*;

	logic                                start_press;
	logic                                bit0_press;
	logic                                bit1_press;
	logic                                in_valid;
	logic                                in_ready;
	packet_t                             in_pkt;
	logic [NUM_CLASSES-1:0]              pushes;
	logic [NUM_CLASSES-1:0]              pops;
	logic [NUM_CLASSES-1:0][DATA_W-1:0]   heads;
	logic [NUM_CLASSES-1:0][WEIGHT_W-1:0] weights;

	key_debounce i_start_debounce (.clk, .reset, .key(start_key), .pressed(start_press));
	key_debounce i_key0_debounce (.clk, .reset, .key(key0), .pressed(bit0_press));
	key_debounce i_key1_debounce (.clk, .reset, .key(key1), .pressed(bit1_press));

	packet_entry i_packet_entry (
		.clk,
		.reset,
		.start_press,
		.bit0_press,
		.bit1_press,
		.in_valid,
		.in_pkt,
		.in_ready
	);

	for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_class
		// accepted packet goes to the buffer named by its class field
		assign pushes[c] = in_valid && in_ready && (in_pkt.cls == CLASS_W'(c));

		class_buffer #(.CLASS_ID(c)) i_class_buffer (
			.clk,
			.reset,
			.push(pushes[c]),
			.push_data(in_pkt.data),
			.pop(pops[c]),
			.fill(fills[c]),
			.head(heads[c]),
			.weight(weights[c])
		);
	end

	read_scheduler i_read_scheduler (
		.clk,
		.reset,
		.fills,
		.heads,
		.weights,
		.pops,
		.in_ready,
		.out_valid,
		.out_pkt,
		.out_ready
	);

endmodule

//--- hw/packet_entry.sv
module packet_entry (
	input  logic             clk,
	input  logic             reset,
	input  logic             start_press,
	input  logic             bit0_press,
	input  logic             bit1_press,
	output logic             in_valid,
	output pkt_pkg::packet_t in_pkt,
	input  logic             in_ready
);
	import pkt_pkg::*;

	logic                         armed;
	logic [1:0]                   bit_cnt; // bits taken so far
	logic [$bits(packet_t)-1:0]   shift_q; // msb first
	logic                         take_bit;

	// start has priority over a data press in the same cycle
	assign take_bit = armed && !in_valid && !start_press && (bit0_press || bit1_press);
	assign in_pkt   = packet_t'(shift_q);

	always_ff @(posedge clk) begin
		if (!reset) begin
			armed    <= 1'b0;
			bit_cnt  <= '0;
			in_valid <= 1'b0;
		end else begin
			if (in_valid && in_ready) begin
				in_valid <= 1'b0;
				armed    <= 1'b0; // wait for the next start
			end else if (start_press && !in_valid) begin
				armed   <= 1'b1;
				bit_cnt <= '0;
			end else if (take_bit) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 2'd3) begin
					in_valid <= 1'b1; // fourth bit completes the packet
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_bit) begin
			shift_q <= {shift_q[$bits(packet_t)-2:0], bit1_press};
		end
	end

endmodule

//--- hw/pkt_pkg.sv
package pkt_pkg;

	localparam int NUM_CLASSES = 4;
	localparam int BUF_DEPTH   = 6;
	localparam int CLASS_W     = 2;
	localparam int DATA_W      = 2;
	localparam int FILL_W      = 3; // holds 0 to BUF_DEPTH
	localparam int WEIGHT_W    = 6;

	// debounce window and read period in clock cycles
	localparam int DEBOUNCE_CYCLES = 16;
	localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES);
	localparam int READ_PERIOD     = 64;
	localparam int TIMER_W         = $clog2(READ_PERIOD);

	// weight of each class at fill levels 0 to BUF_DEPTH
	localparam logic [WEIGHT_W-1:0] WEIGHT_TABLE [NUM_CLASSES][BUF_DEPTH+1] = '{
		'{6'd0, 6'd9, 6'd13, 6'd15, 6'd16, 6'd17, 6'd19}, // class 0
		'{6'd0, 6'd6, 6'd8, 6'd12, 6'd14, 6'd18, 6'd21},  // class 1
		'{6'd0, 6'd3, 6'd5, 6'd7, 6'd11, 6'd19, 6'd23},   // class 2
		'{6'd0, 6'd1, 6'd2, 6'd4, 6'd10, 6'd22, 6'd24}    // class 3
	};

	typedef struct packed {
		logic [CLASS_W-1:0] cls;  // upper two key bits
		logic [DATA_W-1:0]  data; // lower two key bits
	} packet_t;

	typedef logic [NUM_CLASSES-1:0][FILL_W-1:0] fill_vec_t;

endpackage

//--- hw/read_scheduler.sv
module read_scheduler (
	input  logic                                                 clk,
	input  logic                                                 reset,
	input  pkt_pkg::fill_vec_t                                   fills,
	input  logic [pkt_pkg::NUM_CLASSES-1:0][pkt_pkg::DATA_W-1:0]   heads,
	input  logic [pkt_pkg::NUM_CLASSES-1:0][pkt_pkg::WEIGHT_W-1:0] weights,
	output logic [pkt_pkg::NUM_CLASSES-1:0]                      pops,
	output logic                                                 in_ready,
	output logic                                                 out_valid,
	output pkt_pkg::packet_t                                     out_pkt,
	input  logic                                                 out_ready
);
	import pkt_pkg::*;

	logic [TIMER_W-1:0]  timer;
	logic                tick;
	logic                pending;    // a read is owed
	logic                found;      // some buffer is nonempty
	logic [CLASS_W-1:0]  win_idx;
	logic [WEIGHT_W-1:0] win_weight;
	logic                read_go;

	assign tick     = (timer == TIMER_W'(READ_PERIOD - 1));
	assign read_go  = pending && !out_valid && found; // one item in flight
	assign pops     = read_go ? (NUM_CLASSES'(1) << win_idx) : '0;
	assign in_ready = ~|pops; // no push while a buffer is popped

	// highest weight wins, strict compare keeps the lower index on a tie
	always_comb begin
		found      = 1'b0;
		win_idx    = '0;
		win_weight = '0;
		for (int i = 0; i < NUM_CLASSES; i++) begin
			if ((fills[i] != '0) && (!found || (weights[i] > win_weight))) begin
				found      = 1'b1;
				win_idx    = CLASS_W'(i);
				win_weight = weights[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			timer     <= '0;
			pending   <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			timer <= tick ? '0 : timer + 1'b1; // runs on under back-pressure
			if (tick && found) begin
				pending <= 1'b1;
			end else if (read_go || !found) begin
				pending <= 1'b0;
			end
			if (read_go) begin
				out_valid <= 1'b1;
			end else if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (read_go) begin
			out_pkt.cls  <= win_idx;
			out_pkt.data <= heads[win_idx];
		end
	end

endmodule

//--- sim/packet_buffer_properties.sv
module packet_buffer_properties (
	input logic                            clk,
	input logic                            reset,
	input logic                            out_valid,
	input logic                            out_ready,
	input pkt_pkg::packet_t                out_pkt,
	input pkt_pkg::fill_vec_t              fills,
	input logic [pkt_pkg::NUM_CLASSES-1:0] pushes,
	input logic [pkt_pkg::NUM_CLASSES-1:0] pops
);
	timeunit 1ns;
	timeprecision 100ps;
	import pkt_pkg::*;

	int unsigned violations = 0; // failed assertions so far

	a_hold_stable: assert property (@(posedge clk) disable iff (!reset)
		out_valid && !out_ready |=> out_valid && $stable(out_pkt))
		else begin
			$error("out_pkt or out_valid changed under back-pressure");
			violations++;
		end

	for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_fill
		a_fill_bound: assert property (@(posedge clk) disable iff (!reset)
			fills[c] <= FILL_W'(BUF_DEPTH))
			else begin
				$error("fill level above the buffer depth");
				violations++;
			end
	end

	a_one_pop: assert property (@(posedge clk) disable iff (!reset) $onehot0(pops))
		else begin
			$error("more than one buffer popped in a cycle");
			violations++;
		end

	a_no_push_on_pop: assert property (@(posedge clk) disable iff (!reset) !(|pushes && |pops))
		else begin
			$error("push and pop in the same cycle");
			violations++;
		end

endmodule

bind packet_buffer_top packet_buffer_properties i_properties (
	.clk,
	.reset,
	.out_valid,
	.out_ready,
	.out_pkt,
	.fills,
	.pushes,
	.pops
);

//--- sim/tb_packet_buffer.sv
module tb_packet_buffer;
	timeunit 1ns;
	timeprecision 100ps;
	import pkt_pkg::*;

	localparam int KEY_START      = 0;
	localparam int KEY_ZERO       = 1;
	localparam int KEY_ONE        = 2;
	localparam int PRESS_CYCLES   = 24;
	localparam int RELEASE_CYCLES = 24;
	localparam int GLITCH_CYCLES  = 8; // shorter than the debounce window
	localparam int GAP_MAX        = 20;
	localparam int START_LIMIT    = 3 * READ_PERIOD;
	localparam int DRAIN_LIMIT    = 20 * READ_PERIOD;
	localparam int NUM_ROWS       = 16;

	// weights at fill levels 1 to 6
	localparam int FILL_WEIGHTS [NUM_CLASSES][BUF_DEPTH] = '{
		'{9, 13, 15, 16, 17, 19},
		'{6, 8, 12, 14, 18, 21},
		'{3, 5, 7, 11, 19, 23},
		'{1, 2, 4, 10, 22, 24}
	};

	typedef struct packed {
		packet_t   pkt;
		logic      hold;   // out_ready stays low after the row
		logic      glitch; // short pulses and then data presses with no start
		fill_vec_t exp;    // fills once the row has settled
	} row_t;

	logic      clk;
	logic      reset;
	logic      start_key;
	logic      key0;
	logic      key1;
	logic      out_valid;
	packet_t   out_pkt;
	logic      out_ready;
	fill_vec_t fills;

	row_t              rows [NUM_ROWS];
	logic [DATA_W-1:0] model_q [NUM_CLASSES][$]; // oldest entry at the front
	packet_t           exp_pkt;
	logic              in_flight;
	logic              seen_valid;

	packet_buffer_top i_packet_buffer_top (
		.clk,
		.reset,
		.start_key,
		.key0,
		.key1,
		.out_valid,
		.out_pkt,
		.out_ready,
		.fills
	);

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	function automatic int class_weight(input int c);
		int n;
		n = model_q[c].size();
		return (n == 0) ? 0 : FILL_WEIGHTS[c][n-1];
	endfunction

	function automatic int model_count();
		int total;
		total = 0;
		for (int c = 0; c < NUM_CLASSES; c++) begin
			total += model_q[c].size();
		end
		return total;
	endfunction

	task automatic model_push(input packet_t p);
		if (model_q[p.cls].size() == BUF_DEPTH) begin
			void'(model_q[p.cls].pop_front()); // oldest entry is lost on a full buffer
		end
		model_q[p.cls].push_back(p.data);
	endtask

	task automatic predict_read();
		int best;
		best = -1;
		for (int c = 0; c < NUM_CLASSES; c++) begin
			if ((model_q[c].size() != 0) &&
				((best < 0) || (class_weight(c) > class_weight(best)))) begin
				best = c; // strict compare keeps the lower index on a tie
			end
		end
		assert (best >= 0) else stop_run("a read started while no packet was buffered");
		exp_pkt.cls  = CLASS_W'(best);
		exp_pkt.data = model_q[best].pop_front();
		in_flight    = 1'b1;
	endtask

	task automatic drive_key(input int which, input logic level);
		case (which)
			KEY_START: start_key = level;
			KEY_ZERO:  key0 = level;
			default:   key1 = level;
		endcase
	endtask

	task automatic press_key(input int which, input int low_cycles);
		@(negedge clk);
		drive_key(which, 1'b0);
		repeat (low_cycles) @(negedge clk);
		drive_key(which, 1'b1);
		repeat (RELEASE_CYCLES) @(negedge clk);
	endtask

	task automatic enter_packet(input packet_t p, input logic use_start);
		logic [3:0] bits;
		bits = p;
		if (use_start) begin
			press_key(KEY_START, PRESS_CYCLES);
		end
		for (int i = 3; i >= 0; i--) begin
			if (use_start && (i == 0)) begin
				model_push(p); // no read can start before the DUT push lands
			end
			press_key(bits[i] ? KEY_ONE : KEY_ZERO, PRESS_CYCLES);
		end
	endtask

	task automatic check_fills(input int r);
		assert (fills == rows[r].exp) else
			stop_run($sformatf("FAIL %0t ns: row %0d fills %o, expected %o", $time, r, fills,
				rows[r].exp));
	endtask

	task automatic wait_read_started();
		int cycles;
		cycles = 0;
		while (!out_valid) begin
			@(negedge clk);
			cycles++;
			assert (cycles < START_LIMIT) else stop_run("timed out waiting for a read to start");
		end
	endtask

	task automatic drain_buffers();
		int cycles;
		cycles = 0;
		@(negedge clk);
		out_ready = 1'b1;
		while ((model_count() != 0) || in_flight) begin
			@(negedge clk);
			cycles++;
			assert (cycles < DRAIN_LIMIT) else stop_run("timed out while reading the buffers empty");
		end
		out_ready = 1'b0;
		assert (fills == '0) else
			stop_run($sformatf("FAIL %0t ns: fills %o after draining, expected 0", $time, fills));
	endtask

	// reference checker sampled at the rising edge
	always @(posedge clk) begin
		if (reset) begin
			assert (i_packet_buffer_top.i_properties.violations == 0) else
				stop_run("a bound property of the top level failed");
			if (out_valid && !seen_valid) begin
				predict_read();
			end
			if (out_valid) begin
				assert (out_pkt == exp_pkt) else
					stop_run($sformatf("FAIL %0t ns: out_pkt %h, expected %h", $time, out_pkt,
						exp_pkt));
			end
			if (out_valid && out_ready) begin
				in_flight = 1'b0;
			end
			seen_valid = out_valid;
		end
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		void'($urandom(32'h095856ce));
		reset      = 1'b0;
		start_key  = 1'b1;
		key0       = 1'b1;
		key1       = 1'b1;
		out_ready  = 1'b0;
		in_flight  = 1'b0;
		seen_valid = 1'b0;
		exp_pkt    = '0;
		rows = '{
			{2'd3, 2'd2, 1'b1, 1'b0, 12'o0000}, // goes straight into flight
			{2'd1, 2'd1, 1'b0, 1'b0, 12'o0010},
			{2'd2, 2'd3, 1'b1, 1'b1, 12'o0000}, // ignored presses
			{2'd1, 2'd0, 1'b1, 1'b0, 12'o0000}, // blocker under back-pressure
			{2'd0, 2'd0, 1'b1, 1'b0, 12'o0001},
			{2'd0, 2'd1, 1'b1, 1'b0, 12'o0002},
			{2'd0, 2'd2, 1'b1, 1'b0, 12'o0003},
			{2'd0, 2'd3, 1'b1, 1'b0, 12'o0004},
			{2'd0, 2'd0, 1'b1, 1'b0, 12'o0005},
			{2'd0, 2'd1, 1'b1, 1'b0, 12'o0006},
			{2'd0, 2'd2, 1'b1, 1'b0, 12'o0006}, // overflow drops the first class 0 entry
			{2'd2, 2'd3, 1'b1, 1'b0, 12'o0106},
			{2'd2, 2'd2, 1'b1, 1'b0, 12'o0206},
			{2'd2, 2'd1, 1'b1, 1'b0, 12'o0306},
			{2'd2, 2'd0, 1'b1, 1'b0, 12'o0406},
			{2'd2, 2'd3, 1'b0, 1'b0, 12'o0506}  // weight 19 tie between class 0 and 2
		};
		repeat (3) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		assert ((out_valid == 1'b0) && (fills == '0)) else
			stop_run($sformatf("FAIL %0t ns: out_valid %b fills %o after reset", $time, out_valid,
				fills));

		for (int r = 0; r < NUM_ROWS; r++) begin
			repeat ($urandom_range(GAP_MAX, 0)) @(negedge clk);
			if (rows[r].glitch) begin
				press_key(KEY_START, GLITCH_CYCLES);
				press_key(KEY_ZERO, GLITCH_CYCLES);
				press_key(KEY_ONE, GLITCH_CYCLES);
				enter_packet(rows[r].pkt, 1'b0);
				check_fills(r);
			end else begin
				enter_packet(rows[r].pkt, 1'b1);
				wait_read_started();
				check_fills(r);
				repeat (READ_PERIOD + 4) @(negedge clk);
				check_fills(r); // nothing leaves while out_ready is low
				if (!rows[r].hold) begin
					drain_buffers();
				end
			end
		end

		if (i_packet_buffer_top.i_properties.violations == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stop_run("a bound property of the top level failed during the run");
		end
	end

endmodule

//--- src.f
hw/pkt_pkg.sv
hw/key_debounce.sv
hw/packet_entry.sv
hw/class_buffer.sv
hw/read_scheduler.sv
hw/packet_buffer_top.sv
sim/packet_buffer_properties.sv
sim/tb_packet_buffer.sv
